// ==== llc_data_pkg.sv ====
`default_nettype none

package llc_data_pkg;

  // --------------------
  // shared types
  // --------------------

  // source unit of an access
  // doubles as routing tag and round-robin pointer
  typedef enum logic [1:0] {
    EVICT_UNIT  = 2'd0,
    REFILL_UNIT = 2'd1,
    HIT_UNIT    = 2'd2
  } cache_unit_e;

  // kind of access on the way bus
  typedef enum logic {
    OP_READ  = 1'b0,
    OP_WRITE = 1'b1
  } way_op_e;

endpackage

`default_nettype wire

// ==== llc_data_settings.svh ====
`ifndef LLC_DATA_SETTINGS_SVH
`define LLC_DATA_SETTINGS_SVH

// --------------------
// cache geometry
// --------------------

// number of data ways, one sram each
`define LLC_NUM_WAYS 4
// binary way number
`define LLC_WAY_W $clog2(`LLC_NUM_WAYS)
// line index and word offset within a line
`define LLC_INDEX_W 4
`define LLC_OFFSET_W 2
// one data word and its byte enables
`define LLC_DATA_W 64
`define LLC_STRB_W (`LLC_DATA_W / 8)

`endif

// ==== llc_data_sram.sv ====
`default_nettype none

module llc_data_sram #(
  parameter int unsigned NUM_WORDS = 64,
  parameter int unsigned DATA_W    = 64
) (
  input  wire logic                         clk_i,
  input  wire logic                         req_i,
  input  wire logic                         we_i,
  input  wire logic [$clog2(NUM_WORDS)-1:0] addr_i,
  input  wire logic [DATA_W-1:0]            wdata_i,
  input  wire logic [DATA_W/8-1:0]          be_i,
  output logic      [DATA_W-1:0]            rdata_o
);

  localparam int unsigned NUM_BYTES = DATA_W / 8;

  // storage array
  logic [DATA_W-1:0] mem_q [NUM_WORDS];

  // single port, one access per cycle
  always_ff @(posedge clk_i) begin
    if (req_i) begin
      if (we_i) begin
        // byte-wise write, disabled lanes keep old data
        for (int b = 0; b < NUM_BYTES; b++) begin
          if (be_i[b]) begin
            mem_q[addr_i][b*8 +: 8] <= wdata_i[b*8 +: 8];
          end
        end
      end else begin
        // read port registered, one cycle latency
        rdata_o <= mem_q[addr_i];
      end
    end
    // no request: rdata_o keeps the last read word
  end

endmodule

`default_nettype wire

// ==== llc_data_way.sv ====
`default_nettype none

`include "llc_data_settings.svh"

module llc_data_way
  import llc_data_pkg::*;
(
  input  wire logic                     clk_i,
  input  wire logic                     rst_n_i,
  // request side
  input  wire logic                     valid_i,
  output logic                          ready_o,
  input  wire logic [`LLC_INDEX_W-1:0]  index_i,
  input  wire logic [`LLC_OFFSET_W-1:0] offset_i,
  input  way_op_e                       op_i,
  input  wire logic [`LLC_DATA_W-1:0]   wdata_i,
  input  wire logic [`LLC_STRB_W-1:0]   strb_i,
  input  cache_unit_e                   unit_i,
  // read result side
  output logic                          out_valid_o,
  output cache_unit_e                   out_unit_o,
  output logic      [`LLC_DATA_W-1:0]   out_data_o,
  input  wire logic                     out_ready_i
);

  localparam int unsigned ADDR_W = `LLC_INDEX_W + `LLC_OFFSET_W;

  logic [ADDR_W-1:0] sram_addr;
  logic              accept;
  logic              out_valid_q;
  cache_unit_e       out_unit_q;

  // --------------------
  // handshake
  // --------------------

  // free when nothing pending, or the pending result leaves now
  assign ready_o = ~out_valid_q | out_ready_i;
  assign accept  = valid_i & ready_o;

  // line index on top, word offset below
  assign sram_addr = {index_i, offset_i};

  // result valid flag
  // a read sets it, a write or a taken result clears it
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      out_valid_q <= 1'b0;
    end else if (accept) begin
      out_valid_q <= (op_i == OP_READ);
    end else if (out_ready_i) begin
      out_valid_q <= 1'b0;
    end
  end

  // routing tag of the last accepted access
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      out_unit_q <= EVICT_UNIT;
    end else if (accept) begin
      out_unit_q <= unit_i;
    end
  end

  assign out_valid_o = out_valid_q;
  assign out_unit_o  = out_unit_q;

  // --------------------
  // storage
  // --------------------

  // sram only sees accepted transfers, so rdata holds while stalled
  llc_data_sram #(
    .NUM_WORDS (1 << ADDR_W),
    .DATA_W    (`LLC_DATA_W)
  ) u_sram (
    .clk_i   (clk_i),
    .req_i   (accept),
    .we_i    (op_i == OP_WRITE),
    .addr_i  (sram_addr),
    .wdata_i (wdata_i),
    .be_i    (strb_i),
    .rdata_o (out_data_o)
  );

endmodule

`default_nettype wire

// ==== llc_data_ways_checker.sv ====
`default_nettype none

`include "llc_data_settings.svh"

module llc_data_ways_checker (
  input wire logic                   clk_i,
  input wire logic                   rst_n_i,
  // request handshakes
  input wire logic                   refill_valid_i,
  input wire logic                   refill_ready_i,
  input wire logic                   evict_valid_i,
  input wire logic                   evict_ready_i,
  input wire logic                   hit_valid_i,
  input wire logic                   hit_ready_i,
  // read results
  input wire logic                   evict_rvalid_i,
  input wire logic                   evict_rready_i,
  input wire logic [`LLC_DATA_W-1:0] evict_rdata_i,
  input wire logic                   hit_rvalid_i,
  input wire logic                   hit_rready_i,
  input wire logic [`LLC_DATA_W-1:0] hit_rdata_i
);

  // failed assertions so far, read by the testbench
  int unsigned fail_cnt = 0;

  // --------------------
  // response stability
  // --------------------

  // a stalled result keeps valid and data until taken
  a_evict_hold : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    evict_rvalid_i && !evict_rready_i |=> evict_rvalid_i && $stable(evict_rdata_i))
  else begin
    $error("evict result dropped or changed while held");
    fail_cnt++;
  end

  a_hit_hold : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    hit_rvalid_i && !hit_rready_i |=> hit_rvalid_i && $stable(hit_rdata_i))
  else begin
    $error("hit result dropped or changed while held");
    fail_cnt++;
  end

  // --------------------
  // arbitration and reset
  // --------------------

  // one grant per cycle on the shared way bus
  a_one_grant : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $onehot0({refill_valid_i & refill_ready_i, evict_valid_i & evict_ready_i,
              hit_valid_i & hit_ready_i}))
  else begin
    $error("more than one unit granted in a cycle");
    fail_cnt++;
  end

  // registers are cleared one edge into reset
  a_reset_quiet : assert property (@(posedge clk_i)
    !rst_n_i |=> !evict_rvalid_i && !hit_rvalid_i)
  else begin
    $error("read valid raised during reset");
    fail_cnt++;
  end

endmodule

bind llc_data_ways_top llc_data_ways_checker u_checker (
  .clk_i          (clk_i),
  .rst_n_i        (rst_n_i),
  .refill_valid_i (refill_valid_i),
  .refill_ready_i (refill_ready_o),
  .evict_valid_i  (evict_valid_i),
  .evict_ready_i  (evict_ready_o),
  .hit_valid_i    (hit_valid_i),
  .hit_ready_i    (hit_ready_o),
  .evict_rvalid_i (evict_rvalid_o),
  .evict_rready_i (evict_rready_i),
  .evict_rdata_i  (evict_rdata_o),
  .hit_rvalid_i   (hit_rvalid_o),
  .hit_rready_i   (hit_rready_i),
  .hit_rdata_i    (hit_rdata_o)
);

`default_nettype wire

// ==== llc_data_ways_top.sv ====
`default_nettype none

`include "llc_data_settings.svh"

module llc_data_ways_top
  import llc_data_pkg::*;
(
  input  wire logic                     clk_i,
  input  wire logic                     rst_n_i,
  // refill unit
  input  wire logic                     refill_valid_i,
  output logic                          refill_ready_o,
  input  wire logic [`LLC_WAY_W-1:0]    refill_way_i,
  input  wire logic [`LLC_INDEX_W-1:0]  refill_index_i,
  input  wire logic [`LLC_OFFSET_W-1:0] refill_offset_i,
  input  wire logic [`LLC_DATA_W-1:0]   refill_wdata_i,
  input  wire logic [`LLC_STRB_W-1:0]   refill_strb_i,
  // evict unit
  input  wire logic                     evict_valid_i,
  output logic                          evict_ready_o,
  input  wire logic [`LLC_WAY_W-1:0]    evict_way_i,
  input  wire logic [`LLC_INDEX_W-1:0]  evict_index_i,
  input  wire logic [`LLC_OFFSET_W-1:0] evict_offset_i,
  // hit unit
  input  wire logic                     hit_valid_i,
  output logic                          hit_ready_o,
  input  wire logic [`LLC_WAY_W-1:0]    hit_way_i,
  input  wire logic [`LLC_INDEX_W-1:0]  hit_index_i,
  input  wire logic [`LLC_OFFSET_W-1:0] hit_offset_i,
  input  way_op_e                       hit_op_i,
  input  wire logic [`LLC_DATA_W-1:0]   hit_wdata_i,
  input  wire logic [`LLC_STRB_W-1:0]   hit_strb_i,
  // read results
  output logic                          evict_rvalid_o,
  input  wire logic                     evict_rready_i,
  output logic      [`LLC_DATA_W-1:0]   evict_rdata_o,
  output logic                          hit_rvalid_o,
  input  wire logic                     hit_rready_i,
  output logic      [`LLC_DATA_W-1:0]   hit_rdata_o
);

  // shared way bus
  logic [`LLC_NUM_WAYS-1:0] way_valid;
  logic [`LLC_NUM_WAYS-1:0] way_ready;
  logic [`LLC_INDEX_W-1:0]  way_index;
  logic [`LLC_OFFSET_W-1:0] way_offset;
  way_op_e                  way_op;
  logic [`LLC_DATA_W-1:0]   way_wdata;
  logic [`LLC_STRB_W-1:0]   way_strb;
  cache_unit_e              way_unit;

  // read order notice
  logic                     rd_issue;
  cache_unit_e              rd_issue_unit;
  logic [`LLC_WAY_W-1:0]    rd_issue_way;

  // per way results
  logic [`LLC_NUM_WAYS-1:0] out_valid;
  logic [`LLC_NUM_WAYS-1:0] out_ready;
  cache_unit_e              out_unit [`LLC_NUM_WAYS];
  logic [`LLC_DATA_W-1:0]   out_data [`LLC_NUM_WAYS];

  // --------------------
  // request side
  // --------------------

  llc_way_arbiter u_arbiter (
    .clk_i           (clk_i),
    .rst_n_i         (rst_n_i),
    .refill_valid_i  (refill_valid_i),
    .refill_ready_o  (refill_ready_o),
    .refill_way_i    (refill_way_i),
    .refill_index_i  (refill_index_i),
    .refill_offset_i (refill_offset_i),
    .refill_wdata_i  (refill_wdata_i),
    .refill_strb_i   (refill_strb_i),
    .evict_valid_i   (evict_valid_i),
    .evict_ready_o   (evict_ready_o),
    .evict_way_i     (evict_way_i),
    .evict_index_i   (evict_index_i),
    .evict_offset_i  (evict_offset_i),
    .hit_valid_i     (hit_valid_i),
    .hit_ready_o     (hit_ready_o),
    .hit_way_i       (hit_way_i),
    .hit_index_i     (hit_index_i),
    .hit_offset_i    (hit_offset_i),
    .hit_op_i        (hit_op_i),
    .hit_wdata_i     (hit_wdata_i),
    .hit_strb_i      (hit_strb_i),
    .way_valid_o     (way_valid),
    .way_ready_i     (way_ready),
    .way_index_o     (way_index),
    .way_offset_o    (way_offset),
    .way_op_o        (way_op),
    .way_wdata_o     (way_wdata),
    .way_strb_o      (way_strb),
    .way_unit_o      (way_unit),
    .rd_issue_o      (rd_issue),
    .rd_issue_unit_o (rd_issue_unit),
    .rd_issue_way_o  (rd_issue_way)
  );

  // --------------------
  // data ways
  // --------------------

  for (genvar w = 0; w < `LLC_NUM_WAYS; w++) begin : g_way
    llc_data_way u_way (
      .clk_i       (clk_i),
      .rst_n_i     (rst_n_i),
      .valid_i     (way_valid[w]),
      .ready_o     (way_ready[w]),
      .index_i     (way_index),
      .offset_i    (way_offset),
      .op_i        (way_op),
      .wdata_i     (way_wdata),
      .strb_i      (way_strb),
      .unit_i      (way_unit),
      .out_valid_o (out_valid[w]),
      .out_unit_o  (out_unit[w]),
      .out_data_o  (out_data[w]),
      .out_ready_i (out_ready[w])
    );
  end

  // --------------------
  // response side
  // --------------------

  llc_resp_router u_router (
    .clk_i           (clk_i),
    .rst_n_i         (rst_n_i),
    .rd_issue_i      (rd_issue),
    .rd_issue_unit_i (rd_issue_unit),
    .rd_issue_way_i  (rd_issue_way),
    .way_out_valid_i (out_valid),
    .way_out_unit_i  (out_unit),
    .way_out_data_i  (out_data),
    .way_out_ready_o (out_ready),
    .evict_rvalid_o  (evict_rvalid_o),
    .evict_rready_i  (evict_rready_i),
    .evict_rdata_o   (evict_rdata_o),
    .hit_rvalid_o    (hit_rvalid_o),
    .hit_rready_i    (hit_rready_i),
    .hit_rdata_o     (hit_rdata_o)
  );

endmodule

`default_nettype wire

// ==== llc_resp_router.sv ====
`default_nettype none

`include "llc_data_settings.svh"

module llc_resp_router
  import llc_data_pkg::*;
(
  input  wire logic                     clk_i,
  input  wire logic                     rst_n_i,
  // read issue notice from the arbiter
  input  wire logic                     rd_issue_i,
  input  cache_unit_e                   rd_issue_unit_i,
  input  wire logic [`LLC_WAY_W-1:0]    rd_issue_way_i,
  // way results
  input  wire logic [`LLC_NUM_WAYS-1:0] way_out_valid_i,
  input  cache_unit_e                   way_out_unit_i [`LLC_NUM_WAYS],
  input  wire logic [`LLC_DATA_W-1:0]   way_out_data_i [`LLC_NUM_WAYS],
  output logic      [`LLC_NUM_WAYS-1:0] way_out_ready_o,
  // unit responses
  output logic                          evict_rvalid_o,
  input  wire logic                     evict_rready_i,
  output logic      [`LLC_DATA_W-1:0]   evict_rdata_o,
  output logic                          hit_rvalid_o,
  input  wire logic                     hit_rready_i,
  output logic      [`LLC_DATA_W-1:0]   hit_rdata_o
);

  // last slot of an order queue
  localparam logic [`LLC_WAY_W-1:0] LAST = `LLC_WAY_W'(`LLC_NUM_WAYS - 1);

  // slot 0 serves evict, slot 1 serves hit
  logic [1:0]             unit_rvalid;
  logic [1:0]             unit_rready;
  logic [1:0]             unit_pop;
  logic [`LLC_WAY_W-1:0]  unit_head  [2];
  logic [`LLC_DATA_W-1:0] unit_rdata [2];

  assign unit_rready = {hit_rready_i, evict_rready_i};

  // --------------------
  // order queues
  // --------------------

  for (genvar u = 0; u < 2; u++) begin : g_queue
    localparam cache_unit_e QUNIT = (u == 0) ? EVICT_UNIT : HIT_UNIT;

    // way numbers in issue order
    // one read per way at most, so depth never overflows
    logic [`LLC_WAY_W-1:0] slot_q [`LLC_NUM_WAYS];
    logic [`LLC_WAY_W-1:0] wr_ptr_q;
    logic [`LLC_WAY_W-1:0] rd_ptr_q;
    logic [`LLC_WAY_W:0]   cnt_q;
    logic                  push;

    assign push = rd_issue_i & (rd_issue_unit_i == QUNIT);

    always_ff @(posedge clk_i) begin
      if (push) begin
        slot_q[wr_ptr_q] <= rd_issue_way_i;
      end
    end

    always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
        wr_ptr_q <= '0;
        rd_ptr_q <= '0;
        cnt_q    <= '0;
      end else begin
        if (push) begin
          wr_ptr_q <= (wr_ptr_q == LAST) ? '0 : wr_ptr_q + 1'b1;
        end
        if (unit_pop[u]) begin
          rd_ptr_q <= (rd_ptr_q == LAST) ? '0 : rd_ptr_q + 1'b1;
        end
        case ({push, unit_pop[u]})
          2'b10:   cnt_q <= cnt_q + 1'b1;
          2'b01:   cnt_q <= cnt_q - 1'b1;
          default: cnt_q <= cnt_q;
        endcase
      end
    end

    assign unit_head[u] = slot_q[rd_ptr_q];

    // only the head way may answer, and only with a result tagged for us
    assign unit_rvalid[u] = (cnt_q != '0) & way_out_valid_i[unit_head[u]] &
                            (way_out_unit_i[unit_head[u]] == QUNIT);
    assign unit_rdata[u]  = way_out_data_i[unit_head[u]];
    assign unit_pop[u]    = unit_rvalid[u] & unit_rready[u];
  end

  // --------------------
  // back to the ways
  // --------------------

  // ready only to the head way, in the cycle its result is taken
  always_comb begin
    way_out_ready_o = '0;
    for (int u = 0; u < 2; u++) begin
      if (unit_pop[u]) begin
        way_out_ready_o[unit_head[u]] = 1'b1;
      end
    end
  end

  assign evict_rvalid_o = unit_rvalid[0];
  assign evict_rdata_o  = unit_rdata[0];
  assign hit_rvalid_o   = unit_rvalid[1];
  assign hit_rdata_o    = unit_rdata[1];

endmodule

`default_nettype wire

// ==== llc_way_arbiter.sv ====
`default_nettype none

`include "llc_data_settings.svh"

module llc_way_arbiter
  import llc_data_pkg::*;
(
  input  wire logic                     clk_i,
  input  wire logic                     rst_n_i,
  // refill unit, writes only
  input  wire logic                     refill_valid_i,
  output logic                          refill_ready_o,
  input  wire logic [`LLC_WAY_W-1:0]    refill_way_i,
  input  wire logic [`LLC_INDEX_W-1:0]  refill_index_i,
  input  wire logic [`LLC_OFFSET_W-1:0] refill_offset_i,
  input  wire logic [`LLC_DATA_W-1:0]   refill_wdata_i,
  input  wire logic [`LLC_STRB_W-1:0]   refill_strb_i,
  // evict unit, reads only
  input  wire logic                     evict_valid_i,
  output logic                          evict_ready_o,
  input  wire logic [`LLC_WAY_W-1:0]    evict_way_i,
  input  wire logic [`LLC_INDEX_W-1:0]  evict_index_i,
  input  wire logic [`LLC_OFFSET_W-1:0] evict_offset_i,
  // hit unit
  input  wire logic                     hit_valid_i,
  output logic                          hit_ready_o,
  input  wire logic [`LLC_WAY_W-1:0]    hit_way_i,
  input  wire logic [`LLC_INDEX_W-1:0]  hit_index_i,
  input  wire logic [`LLC_OFFSET_W-1:0] hit_offset_i,
  input  way_op_e                       hit_op_i,
  input  wire logic [`LLC_DATA_W-1:0]   hit_wdata_i,
  input  wire logic [`LLC_STRB_W-1:0]   hit_strb_i,
  // way side
  output logic      [`LLC_NUM_WAYS-1:0] way_valid_o,
  input  wire logic [`LLC_NUM_WAYS-1:0] way_ready_i,
  output logic      [`LLC_INDEX_W-1:0]  way_index_o,
  output logic      [`LLC_OFFSET_W-1:0] way_offset_o,
  output way_op_e                       way_op_o,
  output logic      [`LLC_DATA_W-1:0]   way_wdata_o,
  output logic      [`LLC_STRB_W-1:0]   way_strb_o,
  output cache_unit_e                   way_unit_o,
  // read issue notice to the router
  output logic                          rd_issue_o,
  output cache_unit_e                   rd_issue_unit_o,
  output logic      [`LLC_WAY_W-1:0]    rd_issue_way_o
);

  // requests gathered by unit number
  logic [2:0]               req_valid;
  logic [`LLC_WAY_W-1:0]    req_way    [3];
  logic [`LLC_INDEX_W-1:0]  req_index  [3];
  logic [`LLC_OFFSET_W-1:0] req_offset [3];
  way_op_e                  req_op     [3];
  logic [`LLC_DATA_W-1:0]   req_wdata  [3];
  logic [`LLC_STRB_W-1:0]   req_strb   [3];

  cache_unit_e           ptr_q;
  cache_unit_e           win_unit;
  logic                  win_found;
  logic [`LLC_WAY_W-1:0] win_way;
  logic                  grant;

  assign req_valid = {hit_valid_i, refill_valid_i, evict_valid_i};

  // evict carries no write data
  assign req_way[EVICT_UNIT]    = evict_way_i;
  assign req_index[EVICT_UNIT]  = evict_index_i;
  assign req_offset[EVICT_UNIT] = evict_offset_i;
  assign req_op[EVICT_UNIT]     = OP_READ;
  assign req_wdata[EVICT_UNIT]  = '0;
  assign req_strb[EVICT_UNIT]   = '0;

  assign req_way[REFILL_UNIT]    = refill_way_i;
  assign req_index[REFILL_UNIT]  = refill_index_i;
  assign req_offset[REFILL_UNIT] = refill_offset_i;
  assign req_op[REFILL_UNIT]     = OP_WRITE;
  assign req_wdata[REFILL_UNIT]  = refill_wdata_i;
  assign req_strb[REFILL_UNIT]   = refill_strb_i;

  assign req_way[HIT_UNIT]    = hit_way_i;
  assign req_index[HIT_UNIT]  = hit_index_i;
  assign req_offset[HIT_UNIT] = hit_offset_i;
  assign req_op[HIT_UNIT]     = hit_op_i;
  assign req_wdata[HIT_UNIT]  = hit_wdata_i;
  assign req_strb[HIT_UNIT]   = hit_strb_i;

  // --------------------
  // round robin
  // --------------------

  // first valid unit at or after the pointer
  always_comb begin
    int unsigned cand;
    win_found = 1'b0;
    win_unit  = ptr_q;
    for (int k = 0; k < 3; k++) begin
      cand = (int'(ptr_q) + k) % 3;
      if (!win_found && req_valid[cand]) begin
        win_found = 1'b1;
        win_unit  = cache_unit_e'(cand);
      end
    end
  end

  assign win_way = req_way[win_unit];
  // addressed way decides the grant
  assign grant   = win_found & way_ready_i[win_way];

  // pointer moves past the winner on each grant
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      ptr_q <= EVICT_UNIT;
    end else if (grant) begin
      ptr_q <= (win_unit == HIT_UNIT) ? EVICT_UNIT : cache_unit_e'(int'(win_unit) + 1);
    end
  end

  // --------------------
  // steering
  // --------------------

  // one-hot valid to the addressed way only
  assign way_valid_o  = win_found ? (`LLC_NUM_WAYS'(1) << win_way) : '0;
  assign way_index_o  = req_index[win_unit];
  assign way_offset_o = req_offset[win_unit];
  assign way_op_o     = req_op[win_unit];
  assign way_wdata_o  = req_wdata[win_unit];
  assign way_strb_o   = req_strb[win_unit];
  assign way_unit_o   = win_unit;

  assign evict_ready_o  = grant & (win_unit == EVICT_UNIT);
  assign refill_ready_o = grant & (win_unit == REFILL_UNIT);
  assign hit_ready_o    = grant & (win_unit == HIT_UNIT);

  // router learns order of reads here
  assign rd_issue_o      = grant & (req_op[win_unit] == OP_READ);
  assign rd_issue_unit_o = win_unit;
  assign rd_issue_way_o  = win_way;

endmodule

`default_nettype wire

// ==== tb_llc_data_ways.sv ====
`default_nettype none

`include "llc_data_settings.svh"

module tb_llc_data_ways
  import llc_data_pkg::*;
();

  localparam int CLK_PERIOD   = 10;
  localparam int DRIVE_DLY    = 1;
  localparam int RESET_CYCLES = 16;
  localparam int WAY_W        = `LLC_WAY_W;
  localparam int DATA_W       = `LLC_DATA_W;
  localparam int STRB_W       = `LLC_STRB_W;
  // flat word address: way, index, offset
  localparam int ADDR_W       = WAY_W + `LLC_INDEX_W + `LLC_OFFSET_W;
  localparam int NUM_WORDS    = 1 << ADDR_W;
  localparam logic [ADDR_W-1:0] FULL = '1;
  localparam logic [ADDR_W-1:0] TOP  = 1 << (ADDR_W - 1);
  // request counts per phase
  localparam int N_HIT   = 64;
  localparam int N_BP    = 64;
  localparam int N_RR    = 48;
  localparam int N_SPLIT = 32;
  localparam int TOTAL   = 2 * NUM_WORDS + N_HIT + 2 * N_BP + 3 * N_RR + 2 * N_SPLIT;
  localparam int TIMEOUT = 20 * TOTAL + 200;

  logic clk_i;
  logic rst_n_i;
  logic refill_valid_i, refill_ready_o;
  logic [WAY_W-1:0] refill_way_i;
  logic [`LLC_INDEX_W-1:0] refill_index_i;
  logic [`LLC_OFFSET_W-1:0] refill_offset_i;
  logic [DATA_W-1:0] refill_wdata_i;
  logic [STRB_W-1:0] refill_strb_i;
  logic evict_valid_i, evict_ready_o;
  logic [WAY_W-1:0] evict_way_i;
  logic [`LLC_INDEX_W-1:0] evict_index_i;
  logic [`LLC_OFFSET_W-1:0] evict_offset_i;
  logic hit_valid_i, hit_ready_o;
  logic [WAY_W-1:0] hit_way_i;
  logic [`LLC_INDEX_W-1:0] hit_index_i;
  logic [`LLC_OFFSET_W-1:0] hit_offset_i;
  way_op_e hit_op_i;
  logic [DATA_W-1:0] hit_wdata_i;
  logic [STRB_W-1:0] hit_strb_i;
  logic evict_rvalid_o, evict_rready_i, hit_rvalid_o, hit_rready_i;
  logic [DATA_W-1:0] evict_rdata_o, hit_rdata_o;

  // shadow memory and expected read words per unit
  logic [DATA_W-1:0] shadow [NUM_WORDS];
  logic [DATA_W-1:0] evict_exp_q [$];
  logic [DATA_W-1:0] hit_exp_q [$];
  logic [31:0] rng_state = 32'd36;
  // back-pressure enables for the rready driver
  logic evict_bp, hit_bp;
  int   skip_cnt [3];
  int   cycle_cnt;

  llc_data_ways_top dut0 (.*);

  // --------------------
  // helpers
  // --------------------

  function automatic logic [31:0] next_rand();
    rng_state = rng_state * 32'd1664525 + 32'd1013904223;
    return rng_state;
  endfunction

  function automatic logic [DATA_W-1:0] rand_word();
    return DATA_W'({next_rand(), next_rand()});
  endfunction

  // upper lcg bits, masked and forced into an address window
  function automatic logic [ADDR_W-1:0] rand_addr(input logic [ADDR_W-1:0] mask,
                                                  input logic [ADDR_W-1:0] fixed);
    logic [31:0] r;
    r = next_rand();
    return (r[31 -: ADDR_W] & mask) | fixed;
  endfunction

  // reference rule: enabled bytes come from the write, the rest stay
  function automatic logic [DATA_W-1:0] merge_bytes(input logic [DATA_W-1:0] old_word,
                                                    input logic [DATA_W-1:0] new_word,
                                                    input logic [STRB_W-1:0] strb);
    logic [DATA_W-1:0] res;
    res = old_word;
    for (int b = 0; b < STRB_W; b++) begin
      if (strb[b]) res[b*8 +: 8] = new_word[b*8 +: 8];
    end
    return res;
  endfunction

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("TEST FAILED");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [DATA_W-1:0] got,
                             input logic [DATA_W-1:0] exp);
    if (got !== exp) begin
      abort_run($sformatf("Mismatch %s: got 0x%h, expected 0x%h", name, got, exp));
    end
  endtask

  // --------------------
  // unit drivers
  // --------------------

  // called at edge plus delay, returns there after the handshake
  task automatic refill_write(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data,
                              input logic [STRB_W-1:0] strb);
    refill_valid_i  = 1'b1;
    refill_way_i    = addr[ADDR_W-1 -: WAY_W];
    refill_index_i  = addr[`LLC_OFFSET_W +: `LLC_INDEX_W];
    refill_offset_i = addr[`LLC_OFFSET_W-1:0];
    refill_wdata_i  = data;
    refill_strb_i   = strb;
    do @(negedge clk_i); while (!refill_ready_o);
    @(posedge clk_i);
    #DRIVE_DLY;
  endtask

  task automatic evict_read(input logic [ADDR_W-1:0] addr);
    evict_valid_i  = 1'b1;
    evict_way_i    = addr[ADDR_W-1 -: WAY_W];
    evict_index_i  = addr[`LLC_OFFSET_W +: `LLC_INDEX_W];
    evict_offset_i = addr[`LLC_OFFSET_W-1:0];
    do @(negedge clk_i); while (!evict_ready_o);
    @(posedge clk_i);
    #DRIVE_DLY;
  endtask

  task automatic hit_access(input way_op_e op, input logic [ADDR_W-1:0] addr,
                            input logic [DATA_W-1:0] data, input logic [STRB_W-1:0] strb);
    hit_valid_i  = 1'b1;
    hit_op_i     = op;
    hit_way_i    = addr[ADDR_W-1 -: WAY_W];
    hit_index_i  = addr[`LLC_OFFSET_W +: `LLC_INDEX_W];
    hit_offset_i = addr[`LLC_OFFSET_W-1:0];
    hit_wdata_i  = data;
    hit_strb_i   = strb;
    do @(negedge clk_i); while (!hit_ready_o);
    @(posedge clk_i);
    #DRIVE_DLY;
  endtask

  // back-to-back streams keep valid high until the last transfer
  task automatic refill_stream(input int n);
    @(posedge clk_i);
    #DRIVE_DLY;
    for (int i = 0; i < n; i++) refill_write(rand_addr(FULL, '0), rand_word(), '1);
    refill_valid_i = 1'b0;
  endtask

  task automatic evict_stream(input int n, input logic [ADDR_W-1:0] mask,
                              input logic [ADDR_W-1:0] fixed);
    @(posedge clk_i);
    #DRIVE_DLY;
    for (int i = 0; i < n; i++) evict_read(rand_addr(mask, fixed));
    evict_valid_i = 1'b0;
  endtask

  // random mix of reads and partial-strobe writes
  task automatic hit_stream(input int n, input logic [ADDR_W-1:0] mask,
                            input logic [ADDR_W-1:0] fixed);
    logic [31:0] r;
    @(posedge clk_i);
    #DRIVE_DLY;
    for (int i = 0; i < n; i++) begin
      r = next_rand();
      hit_access(r[31] ? OP_WRITE : OP_READ, rand_addr(mask, fixed), rand_word(),
                 r[16 +: STRB_W]);
    end
    hit_valid_i = 1'b0;
  endtask

  task automatic wait_drained();
    do @(negedge clk_i); while (evict_exp_q.size() != 0 || hit_exp_q.size() != 0);
  endtask

  // --------------------
  // clock and rready
  // --------------------

  initial begin
    clk_i = 1'b0;
    forever begin
      #(CLK_PERIOD / 2);
      clk_i = ~clk_i;
    end
  end

  initial begin
    logic [31:0] r;
    forever begin
      @(posedge clk_i);
      #DRIVE_DLY;
      r = next_rand();
      evict_rready_i = evict_bp ? r[31] : 1'b1;
      hit_rready_i   = hit_bp ? r[30] : 1'b1;
    end
  end

  // --------------------
  // monitor and compare
  // --------------------

  // sampled mid-cycle, where inputs and combinational outputs are settled
  initial begin
    logic [DATA_W-1:0] exp_word;
    logic [2:0] valids;
    logic [2:0] grants;
    forever begin
      @(negedge clk_i);
      cycle_cnt++;
      if (cycle_cnt > TIMEOUT) begin
        abort_run($sformatf("timeout: run still busy after %0d cycles", TIMEOUT));
      end
      if (dut0.u_checker.fail_cnt != 0) abort_run("an assertion in the checker failed");
      // a result with nothing outstanding is an extra or early response
      if (evict_rvalid_o === 1'b1 && evict_exp_q.size() == 0) begin
        abort_run("evict_rvalid_o high with no evict read outstanding");
      end
      if (hit_rvalid_o === 1'b1 && hit_exp_q.size() == 0) begin
        abort_run("hit_rvalid_o high with no hit read outstanding");
      end
      if (evict_rvalid_o && evict_rready_i) begin
        exp_word = evict_exp_q.pop_front();
        check_value("evict_rdata_o", evict_rdata_o, exp_word);
      end
      if (hit_rvalid_o && hit_rready_i) begin
        exp_word = hit_exp_q.pop_front();
        check_value("hit_rdata_o", hit_rdata_o, exp_word);
      end
      // requests, at most one granted per cycle
      if (refill_valid_i && refill_ready_o) begin
        shadow[{refill_way_i, refill_index_i, refill_offset_i}] = merge_bytes(
          shadow[{refill_way_i, refill_index_i, refill_offset_i}], refill_wdata_i,
          refill_strb_i);
      end
      if (evict_valid_i && evict_ready_o) begin
        evict_exp_q.push_back(shadow[{evict_way_i, evict_index_i, evict_offset_i}]);
      end
      if (hit_valid_i && hit_ready_o) begin
        if (hit_op_i == OP_WRITE) begin
          shadow[{hit_way_i, hit_index_i, hit_offset_i}] = merge_bytes(
            shadow[{hit_way_i, hit_index_i, hit_offset_i}], hit_wdata_i, hit_strb_i);
        end else begin
          hit_exp_q.push_back(shadow[{hit_way_i, hit_index_i, hit_offset_i}]);
        end
      end
      // round robin: a waiting unit sees at most two other grants
      valids = {hit_valid_i, refill_valid_i, evict_valid_i};
      grants = valids & {hit_ready_o, refill_ready_o, evict_ready_o};
      for (int u = 0; u < 3; u++) begin
        if (rst_n_i !== 1'b1 || !valids[u] || grants[u]) begin
          skip_cnt[u] = 0;
        end else if (grants != 3'b000) begin
          skip_cnt[u]++;
          if (skip_cnt[u] > 2) begin
            abort_run($sformatf("unit %0d passed over by three grants in a row", u));
          end
        end
      end
    end
  end

  // --------------------
  // test sequence
  // --------------------

  initial begin
    rst_n_i         = 1'b0;
    refill_valid_i  = 1'b0;
    refill_way_i    = '0;
    refill_index_i  = '0;
    refill_offset_i = '0;
    refill_wdata_i  = '0;
    refill_strb_i   = '0;
    evict_valid_i   = 1'b0;
    evict_way_i     = '0;
    evict_index_i   = '0;
    evict_offset_i  = '0;
    hit_valid_i     = 1'b0;
    hit_op_i        = OP_READ;
    hit_way_i       = '0;
    hit_index_i     = '0;
    hit_offset_i    = '0;
    hit_wdata_i     = '0;
    hit_strb_i      = '0;
    evict_rready_i  = 1'b1;
    hit_rready_i    = 1'b1;
    evict_bp        = 1'b0;
    hit_bp          = 1'b0;
    cycle_cnt       = 0;
    skip_cnt        = '{default: 0};
    repeat (RESET_CYCLES) @(posedge clk_i);
    #DRIVE_DLY;
    rst_n_i = 1'b1;
    // idle, the monitor flags any stray rvalid
    repeat (8) @(posedge clk_i);
    // fill every word, then read all back in order
    #DRIVE_DLY;
    for (int a = 0; a < NUM_WORDS; a++) refill_write(ADDR_W'(a), rand_word(), '1);
    refill_valid_i = 1'b0;
    for (int a = 0; a < NUM_WORDS; a++) evict_read(ADDR_W'(a));
    evict_valid_i = 1'b0;
    wait_drained();
    // partial writes on a small window so reads hit merged words
    hit_stream(N_HIT, ADDR_W'(7), '0);
    wait_drained();
    // random back-pressure on both units
    evict_bp = 1'b1;
    hit_bp   = 1'b1;
    fork
      evict_stream(N_BP, FULL, '0);
      hit_stream(N_BP, FULL, '0);
    join
    wait_drained();
    evict_bp = 1'b0;
    hit_bp   = 1'b0;
    // all three units requesting without a gap
    fork
      refill_stream(N_RR);
      evict_stream(N_RR, FULL, '0);
      hit_stream(N_RR, FULL, '0);
    join
    wait_drained();
    // evict on the low ways under back-pressure, hit on the high ways
    evict_bp = 1'b1;
    fork
      evict_stream(N_SPLIT, ~TOP, '0);
      hit_stream(N_SPLIT, ~TOP, TOP);
    join
    wait_drained();
    evict_bp = 1'b0;
    repeat (4) @(negedge clk_i);
    if (dut0.u_checker.fail_cnt != 0) begin
      abort_run("an assertion in the checker failed");
    end else begin
      $display("TEST OK");
      $finish;
    end
  end

endmodule

`default_nettype wire

// ==== verilog.f ====
+incdir+.
llc_data_pkg.sv
llc_data_sram.sv
llc_data_way.sv
llc_way_arbiter.sv
llc_resp_router.sv
llc_data_ways_top.sv
llc_data_ways_checker.sv
tb_llc_data_ways.sv
